// File: files.f
+incdir+include
source/cacheGeomPkg.sv
source/cacheBusPkg.sv
source/cacheArray.sv
source/lineStatus.sv
source/tagMatch.sv
source/lineData.sv
source/cacheControl.sv
source/cacheTop.sv
verif/memoryModel.sv
verif/cacheTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module cacheTb \
    -f files.f -o simCache > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simCache > sim.log 2>&1 || echo "simulation ended with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log

// File: verif/cacheTb.sv
module cacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    // how a row's read data is judged
    localparam logic [1:0] noCheck = 2'd0;
    localparam logic [1:0] fixedValue = 2'd1;
    localparam logic [1:0] modelValue = 2'd2;
    localparam int resetCycles = 10;
    localparam int cyclesPerRow = 60;

    typedef struct packed {
        logic write;
        logic [31:0] addr;
        cacheGeomPkg::wordT data;
        cacheGeomPkg::byteMaskT mask;
        logic [1:0] check;
        logic hitOnly;
        cacheGeomPkg::wordT expected;
    } rowT;

    logic clock;
    logic reset;
    cacheBusPkg::cpuReqT cpuReq;
    cacheBusPkg::cpuRspT cpuRsp;
    cacheBusPkg::memReqT memReq;
    cacheBusPkg::memRspT memRsp;

    rowT rows[$];
    string names[$];
    // bytes written so far by byte address
    logic [7:0] storedBytes [logic [31:0]];
    string currentTest;
    int cycleCount;
    int cycleLimit;
    int passed;
    int failed;
    int busErrors;
    // beat number within the current writeback burst
    logic writeBeat;

    cacheTop dut (
        .clock(clock), .reset(reset), .cpuReq(cpuReq), .cpuRsp(cpuRsp),
        .memReq(memReq), .memRsp(memRsp)
    );

    memoryModel memory (.clock(clock), .reset(reset), .memReq(memReq), .memRsp(memRsp));

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // power-up word holds its address in the low half and the inverse above
    function automatic logic [7:0] fillByte(input logic [31:0] addr);
        logic [31:0] base;
        logic [63:0] word;
        base = {addr[31:3], 3'b000};
        word = {~base, base};
        return word[{addr[2:0], 3'b000} +: 8];
    endfunction

    function automatic logic [7:0] knownByte(input logic [31:0] addr);
        if (storedBytes.exists(addr)) begin
            return storedBytes[addr];
        end
        return fillByte(addr);
    endfunction

    // 8 bytes from the offset with zeros past the line end
    function automatic cacheGeomPkg::wordT expectedRead(input logic [31:0] addr);
        cacheGeomPkg::wordT word;
        int offset;
        word = '0;
        offset = int'(addr[3:0]);
        for (int i = 0; i < 8; i++) begin
            if (offset + i < cacheGeomPkg::lineBytes) begin
                word[i*8 +: 8] = knownByte(addr + 32'(i));
            end
        end
        return word;
    endfunction

    // only legal widths store and bytes past the line end are lost
    task automatic storeBytes(input logic [31:0] addr, input cacheGeomPkg::wordT data,
        input cacheGeomPkg::byteMaskT mask);
        int width;
        int offset;
        case (mask)
            8'h01: width = 1;
            8'h03: width = 2;
            8'h0f: width = 4;
            8'hff: width = 8;
            default: width = 0;
        endcase
        offset = int'(addr[3:0]);
        for (int i = 0; i < width; i++) begin
            if (offset + i < cacheGeomPkg::lineBytes) begin
                storedBytes[addr + 32'(i)] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic addRow(input string name, input logic write, input logic [31:0] addr,
        input cacheGeomPkg::wordT data, input cacheGeomPkg::byteMaskT mask,
        input logic [1:0] check, input logic hitOnly, input cacheGeomPkg::wordT expected);
        rows.push_back(rowT'{write, addr, data, mask, check, hitOnly, expected});
        names.push_back(name);
    endtask

    task automatic buildTable();
        // cold miss then hit on set 0
        addRow("coldRead", 1'b0, 32'h0000_1000, '0, '0, fixedValue, 1'b0,
            64'hffff_efff_0000_1000);
        addRow("hitRead", 1'b0, 32'h0000_1000, '0, '0, fixedValue, 1'b1,
            64'hffff_efff_0000_1000);
        // write hits of every legal width
        addRow("write1", 1'b1, 32'h0000_1003, 64'h0000_0000_0000_00a5, 8'h01, noCheck, 1'b1, '0);
        addRow("write2", 1'b1, 32'h0000_1006, 64'h0000_0000_0000_beef, 8'h03, noCheck, 1'b1, '0);
        addRow("write4", 1'b1, 32'h0000_1009, 64'h0000_0000_1234_5678, 8'h0f, noCheck, 1'b1, '0);
        addRow("write8", 1'b1, 32'h0000_100c, 64'h0102_0304_0506_0708, 8'hff, noCheck, 1'b1, '0);
        addRow("readLow", 1'b0, 32'h0000_1000, '0, '0, modelValue, 1'b1, '0);
        addRow("readHigh", 1'b0, 32'h0000_1008, '0, '0, modelValue, 1'b1, '0);
        // 8'h07 is not a legal width
        addRow("badMask", 1'b1, 32'h0000_1000, '1, 8'h07, noCheck, 1'b1, '0);
        addRow("readAfterBad", 1'b0, 32'h0000_1000, '0, '0, modelValue, 1'b1, '0);
        addRow("writeEdge", 1'b1, 32'h0000_100f, 64'h0000_0000_0000_aabb, 8'h03, noCheck, 1'b1, '0);
        // upper 4 bytes of a fresh line with zeros above
        addRow("coldOffset12", 1'b0, 32'h0000_200c, '0, '0, fixedValue, 1'b0,
            64'h0000_0000_ffff_dff7);
        addRow("readEdge", 1'b0, 32'h0000_100c, '0, '0, modelValue, 1'b0, '0);
        // six tags into the four ways of set 3 force dirty evictions
        addRow("evictWrite1", 1'b1, 32'h0001_0034, 64'hc1c1_0001_d1d1_0001, 8'hff, noCheck, 1'b0, '0);
        addRow("evictWrite2", 1'b1, 32'h0002_0034, 64'hc2c2_0002_d2d2_0002, 8'h0f, noCheck, 1'b0, '0);
        addRow("evictWrite3", 1'b1, 32'h0003_0034, 64'hc3c3_0003_d3d3_0003, 8'hff, noCheck, 1'b0, '0);
        addRow("evictWrite4", 1'b1, 32'h0004_0034, 64'hc4c4_0004_d4d4_0004, 8'h03, noCheck, 1'b0, '0);
        addRow("evictWrite5", 1'b1, 32'h0005_0034, 64'hc5c5_0005_d5d5_0005, 8'hff, noCheck, 1'b0, '0);
        addRow("evictWrite6", 1'b1, 32'h0006_0034, 64'hc6c6_0006_d6d6_0006, 8'hff, noCheck, 1'b0, '0);
        addRow("evictRead1", 1'b0, 32'h0001_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead2", 1'b0, 32'h0002_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead3", 1'b0, 32'h0003_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead4", 1'b0, 32'h0004_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead5", 1'b0, 32'h0005_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead6", 1'b0, 32'h0006_0030, '0, '0, modelValue, 1'b0, '0);
        addRow("evictRead1High", 1'b0, 32'h0001_0038, '0, '0, modelValue, 1'b0, '0);
        addRow("finalRead", 1'b0, 32'h0000_1000, '0, '0, modelValue, 1'b0, '0);
    endtask

    task automatic runRow(input int index);
        rowT row;
        int latency;
        logic ok;
        cacheGeomPkg::wordT expected;
        cacheGeomPkg::wordT actual;
        row = rows[index];
        currentTest = names[index];
        ok = 1'b1;
        expected = (row.check == modelValue) ? expectedRead(row.addr) : row.expected;
        @(posedge clock);
        #1;
        cpuReq.strobe = 1'b1;
        cpuReq.write = row.write;
        cpuReq.addr = cacheGeomPkg::addrT'(row.addr);
        cpuReq.writeData = row.data;
        cpuReq.mask = row.mask;
        // one-cycle strobe then wait for the completion
        latency = 0;
        do begin
            @(posedge clock);
            #1;
            cpuReq.strobe = 1'b0;
            latency++;
        end while (!cpuRsp.dataOk);
        actual = cpuRsp.readData;
        if (row.write) begin
            storeBytes(row.addr, row.data, row.mask);
        end
        if (row.check != noCheck) begin
            assert (actual == expected) else begin
                $display("FAILED %s expected %h actual %h", names[index], expected, actual);
                ok = 1'b0;
            end
        end
        if (row.hitOnly) begin
            assert (latency == 2) else begin
                $display("%s took %0d cycles but a hit must finish in 2", names[index], latency);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passed++;
            $display("PASS   %s after %0d cycles", names[index], latency);
        end else begin
            failed++;
            $display("FAIL   %s", names[index]);
        end
    endtask

    // idle outputs straight out of reset
    task automatic checkReset();
        assert (!cpuRsp.dataOk && !memReq.arValid && !memReq.awValid && !memReq.wValid &&
            !memReq.rReady) else begin
            $display("after reset dataOk or a bus valid output is still high");
            failed++;
            return;
        end
        passed++;
        $display("PASS   resetState");
    endtask

    // bus rules sampled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            assert (!(memReq.arValid && memReq.awValid)) else begin
                $display("arValid and awValid were high in the same cycle");
                busErrors++;
            end
            if (memReq.awValid) begin
                assert (memReq.awAddr[3:0] == 4'h0) else begin
                    $display("write address %h is not line aligned", memReq.awAddr);
                    busErrors++;
                end
            end
            if (memReq.arValid) begin
                assert (memReq.arAddr[3:0] == 4'h0) else begin
                    $display("read address %h is not line aligned", memReq.arAddr);
                    busErrors++;
                end
            end
            // a new write burst starts at beat 0
            if (memReq.awValid && memRsp.awReady) begin
                writeBeat = 1'b0;
            end
            // only the second beat of a writeback carries wLast
            if (memReq.wValid && memRsp.wReady) begin
                assert (memReq.wLast == writeBeat) else begin
                    $display("wLast was %b on write beat %0d", memReq.wLast, writeBeat);
                    busErrors++;
                end
                writeBeat = !writeBeat;
            end
        end
    end

    // run length limit
    always @(posedge clock) begin
        if (!reset) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("timeout: %s got no dataOk within %0d cycles", currentTest, cycleLimit);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    initial begin
        reset = 1'b1;
        cpuReq = '0;
        passed = 0;
        failed = 0;
        busErrors = 0;
        writeBeat = 1'b0;
        cycleCount = 0;
        currentTest = "resetState";
        buildTable();
        cycleLimit = cyclesPerRow * rows.size();
        repeat (resetCycles) @(posedge clock);
        #1;
        reset = 1'b0;
        checkReset();
        foreach (rows[i]) begin
            runRow(i);
        end
        @(posedge clock);
        $display("tests %0d, passed %0d, failed %0d, bus errors %0d",
            rows.size() + 1, passed, failed, busErrors);
        if (failed == 0 && busErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

// File: verif/memoryModel.sv
module memoryModel (
    input  logic clock,
    input  logic reset,
    input  cacheBusPkg::memReqT memReq,
    output cacheBusPkg::memRspT memRsp
);
    timeunit 1ns;
    timeprecision 100ps;

    // written words by word address, anything else still holds the fill pattern
    cacheGeomPkg::wordT words [logic [28:0]];
    logic [31:0] lfsr;
    logic readActive;
    logic readBeat;
    logic [28:0] readIndex;
    logic writeActive;
    logic writeBeat;
    logic [28:0] writeIndex;
    logic holdBeat;

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // each word holds its own byte address, inverted copy on top
    function automatic cacheGeomPkg::wordT fillWord(input logic [28:0] index);
        logic [31:0] base;
        base = {index, 3'b000};
        return {~base, base};
    endfunction

    function automatic cacheGeomPkg::wordT readMemory(input logic [28:0] index);
        if (words.exists(index)) begin
            return words[index];
        end
        return fillWord(index);
    endfunction

    initial begin
        lfsr = 32'h61a9_10ea;
        readActive = 1'b0;
        readBeat = 1'b0;
        readIndex = '0;
        writeActive = 1'b0;
        writeBeat = 1'b0;
        writeIndex = '0;
        memRsp = '0;
        forever begin
            // handshakes of the cycle, sampled mid-cycle
            @(negedge clock);
            holdBeat = memRsp.rValid && !memReq.rReady;
            if (reset) begin
                readActive = 1'b0;
                writeActive = 1'b0;
                holdBeat = 1'b0;
            end else begin
                if (memReq.arValid && memRsp.arReady) begin
                    readActive = 1'b1;
                    readBeat = 1'b0;
                    readIndex = memReq.arAddr[31:3];
                end
                if (memReq.awValid && memRsp.awReady) begin
                    writeActive = 1'b1;
                    writeBeat = 1'b0;
                    writeIndex = memReq.awAddr[31:3];
                end
                // burst address steps here, beat 1 is the upper word
                if (memReq.wValid && memRsp.wReady) begin
                    words[{writeIndex[28:1], writeBeat}] = memReq.wData;
                    writeActive = !writeBeat;
                    writeBeat = 1'b1;
                end
                if (memReq.rReady && memRsp.rValid) begin
                    readActive = !readBeat;
                    readBeat = 1'b1;
                end
            end
            // new response just after the edge
            @(posedge clock);
            #1;
            lfsr = lfsrStep(lfsr);
            memRsp.arReady = !readActive && lfsr[0];
            lfsr = lfsrStep(lfsr);
            memRsp.awReady = !writeActive && lfsr[0];
            lfsr = lfsrStep(lfsr);
            memRsp.wReady = writeActive && lfsr[0];
            // an offered read beat stays until it is taken
            if (!holdBeat) begin
                lfsr = lfsrStep(lfsr);
                memRsp.rValid = readActive && lfsr[0];
                memRsp.rLast = readBeat;
                memRsp.rData = readMemory({readIndex[28:1], readBeat});
            end
        end
    end
endmodule

// File: source/cacheTop.sv
module cacheTop (
    input  logic clock,
    input  logic reset,
    input  cacheBusPkg::cpuReqT cpuReq,
    output cacheBusPkg::cpuRspT cpuRsp,
    output cacheBusPkg::memReqT memReq,
    input  cacheBusPkg::memRspT memRsp
);
    cacheBusPkg::cpuReqT request;
    logic dataOk;
    logic hit;
    cacheGeomPkg::wayT hitWay;
    logic valid;
    logic dirty;
    logic [cacheGeomPkg::ways-1:0] wayValid;
    cacheGeomPkg::tagT victimTag;
    cacheGeomPkg::lineIndexT lineIndex;
    cacheGeomPkg::wayT victimWay;
    logic tagWrite;
    logic hitWrite;
    logic refillWrite;
    logic beat;
    logic setValid;
    logic dirtyWrite;
    logic dirtyValue;
    cacheGeomPkg::wordT readWord;
    cacheGeomPkg::wordT wbData;

    // completion strobe and aligned read word
    assign cpuRsp.dataOk = dataOk;
    assign cpuRsp.readData = readWord;

    cacheControl control (.*);

    lineStatus status (
        .clock(clock), .reset(reset), .lineIndex(lineIndex),
        .setValid(setValid), .dirtyWrite(dirtyWrite), .dirtyValue(dirtyValue),
        .valid(valid), .dirty(dirty), .wayValid(wayValid)
    );

    // refill writes the victim way, same as the writeback source
    tagMatch tags (
        .clock(clock), .set(request.addr.set), .tag(request.addr.tag),
        .lineValid(wayValid), .tagWrite(tagWrite), .writeWay(victimWay),
        .victimWay(victimWay), .hit(hit), .hitWay(hitWay), .victimTag(victimTag)
    );

    // one beat counter serves both refill and writeback
    lineData data (
        .clock(clock), .lineIndex(lineIndex), .offset(request.addr.offset),
        .hitWrite(hitWrite), .writeData(request.writeData), .writeMask(request.mask),
        .refillWrite(refillWrite), .refillBeat(beat), .refillData(memRsp.rData),
        .wbBeat(beat), .readWord(readWord), .wbData(wbData)
    );
endmodule

// File: source/cacheControl.sv
`include "cache_cfg.svh"

module cacheControl (
    input  logic clock,
    input  logic reset,
    input  cacheBusPkg::cpuReqT cpuReq,
    output cacheBusPkg::cpuReqT request,
    output logic dataOk,
    input  logic hit,
    input  cacheGeomPkg::wayT hitWay,
    input  logic valid,
    input  logic dirty,
    input  cacheGeomPkg::tagT victimTag,
    input  cacheGeomPkg::wordT wbData,
    output cacheGeomPkg::lineIndexT lineIndex,
    output cacheGeomPkg::wayT victimWay,
    output logic tagWrite,
    output logic hitWrite,
    output logic refillWrite,
    output logic beat,
    output logic setValid,
    output logic dirtyWrite,
    output logic dirtyValue,
    output cacheBusPkg::memReqT memReq,
    input  cacheBusPkg::memRspT memRsp
);
    typedef enum logic [2:0] {idle, lookup, miss, replace, refill} stateT;

    stateT state;
    stateT nextState;
    cacheBusPkg::cpuReqT reqLatch;
    logic [15:0] lfsr;
    logic accept;
    logic needWriteback;
    logic awFire;
    logic arFire;
    logic wFire;
    logic rFire;

    assign accept = (state == idle) && cpuReq.strobe;
    // strobe cycle goes straight to the arrays so the tag read starts in idle
    assign request = accept ? cpuReq : reqLatch;

    // payload held until the next strobe
    always_ff @(posedge clock) begin
        if (accept) begin
            reqLatch <= cpuReq;
        end
    end

    // free-running with taps 0 2 3 5
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    // victim picked on the missing lookup and kept through refill
    always_ff @(posedge clock) begin
        if (reset) begin
            victimWay <= '0;
        end else if (state == lookup && !hit) begin
            victimWay <= cacheGeomPkg::wayT'(lfsr);
        end
    end

    // hit way while looking up and victim way during miss handling
    assign lineIndex = (state == idle || state == lookup) ?
        {request.addr.set, hitWay} : {request.addr.set, victimWay};

    assign needWriteback = valid && dirty;

    // bus outputs from state and beat only
    always_comb begin
        memReq = '0;
        memReq.awValid = (state == miss) && needWriteback;
        memReq.awAddr = {victimTag, request.addr.set, cacheGeomPkg::offsetT'(0)};
        memReq.arValid = (state == miss) && !needWriteback;
        memReq.arAddr = {request.addr.tag, request.addr.set, cacheGeomPkg::offsetT'(0)};
        memReq.wValid = state == replace;
        memReq.wData = wbData;
        memReq.wLast = (state == replace) && beat;
        memReq.rReady = state == refill;
    end

    assign awFire = memReq.awValid && memRsp.awReady;
    assign arFire = memReq.arValid && memRsp.arReady;
    assign wFire = memReq.wValid && memRsp.wReady;
    assign rFire = memReq.rReady && memRsp.rValid;

    // beat within the two-beat burst
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (awFire || arFire) begin
            beat <= 1'b0;
        end else if (wFire || rFire) begin
            beat <= !beat;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: if (cpuReq.strobe) nextState = lookup;
            lookup: nextState = hit ? idle : miss;
            // writeback first when the victim is dirty
            miss: begin
                if (awFire) begin
                    nextState = replace;
                end else if (arFire) begin
                    nextState = refill;
                end
            end
            // back to miss, which then issues the refill
            replace: if (wFire && memReq.wLast) nextState = miss;
            // repeat the lookup which hits now
            refill: if (rFire && memRsp.rLast) nextState = lookup;
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            dataOk <= 1'b0;
        end else begin
            state <= nextState;
            // data array read lands one cycle after the hit
            dataOk <= (state == lookup) && hit;
        end
    end

    assign hitWrite = (state == lookup) && hit && request.write;
    assign refillWrite = rFire;
    // tag early on the first beat so the repeated lookup reads it back
    assign tagWrite = rFire && !beat;
    assign setValid = rFire && memRsp.rLast;
    // dirty on write hit and clean once the writeback is done
    assign dirtyWrite = hitWrite || (wFire && memReq.wLast);
    assign dirtyValue = state == lookup;

    // a pending address request holds with the same address until accepted
    assert property (@(posedge clock) disable iff (reset)
        memReq.awValid && !memRsp.awReady |=> memReq.awValid && $stable(memReq.awAddr));
    assert property (@(posedge clock) disable iff (reset)
        memReq.arValid && !memRsp.arReady |=> memReq.arValid && $stable(memReq.arAddr));
endmodule

// File: source/lineData.sv
module lineData (
    input  logic clock,
    input  cacheGeomPkg::lineIndexT lineIndex,
    input  cacheGeomPkg::offsetT offset,
    input  logic hitWrite,
    input  cacheGeomPkg::wordT writeData,
    input  cacheGeomPkg::byteMaskT writeMask,
    input  logic refillWrite,
    input  logic refillBeat,
    input  cacheGeomPkg::wordT refillData,
    input  logic wbBeat,
    output cacheGeomPkg::wordT readWord,
    output cacheGeomPkg::wordT wbData
);
    localparam int wordBits = $bits(cacheGeomPkg::wordT);

    cacheGeomPkg::lineT readLine;
    cacheGeomPkg::lineT shiftedLine;
    cacheGeomPkg::lineT hitMask;
    cacheGeomPkg::lineT hitData;
    cacheGeomPkg::lineT arrayMask;
    cacheGeomPkg::lineT arrayData;
    cacheGeomPkg::wordT wordMask;
    logic [$bits(cacheGeomPkg::offsetT)+2:0] bitShift;

    // byte offset to bit offset
    assign bitShift = {offset, 3'b000};

    // byte mask to bit mask, only the four legal widths
    always_comb begin
        case (writeMask)
            8'h01: wordMask = cacheGeomPkg::wordT'(64'h0000_0000_0000_00ff);
            8'h03: wordMask = cacheGeomPkg::wordT'(64'h0000_0000_0000_ffff);
            8'h0f: wordMask = cacheGeomPkg::wordT'(64'h0000_0000_ffff_ffff);
            8'hff: wordMask = '1;
            default: wordMask = '0;
        endcase
    end

    // bytes shifted past the line end fall off the top
    assign hitMask = cacheGeomPkg::lineT'(wordMask) << bitShift;
    assign hitData = cacheGeomPkg::lineT'(writeData) << bitShift;

    // hit write or refill half, beat 0 is the lower half
    always_comb begin
        if (hitWrite) begin
            arrayMask = hitMask;
            arrayData = hitData;
        end else if (refillBeat) begin
            arrayMask = {{wordBits{1'b1}}, {wordBits{1'b0}}};
            arrayData = {refillData, {wordBits{1'b0}}};
        end else begin
            arrayMask = {{wordBits{1'b0}}, {wordBits{1'b1}}};
            arrayData = {{wordBits{1'b0}}, refillData};
        end
    end

    cacheArray #(
        .payloadT(cacheGeomPkg::lineT),
        .depth(cacheGeomPkg::sets * cacheGeomPkg::ways)
    ) dataRam (
        .clock(clock),
        .address(lineIndex),
        .writeEnable(hitWrite || refillWrite),
        .writeMask(arrayMask),
        .writeData(arrayData),
        .readData(readLine)
    );

    // zeros shift in above the line end
    assign shiftedLine = readLine >> bitShift;
    assign readWord = shiftedLine[wordBits-1:0];
    // writeback beat select
    assign wbData = wbBeat ? readLine[2*wordBits-1:wordBits] : readLine[wordBits-1:0];

    // controller never overlaps a hit write with a refill beat
    assert property (@(posedge clock) !(hitWrite && refillWrite));
endmodule

// File: source/tagMatch.sv
module tagMatch (
    input  logic clock,
    input  cacheGeomPkg::setT set,
    input  cacheGeomPkg::tagT tag,
    input  logic [cacheGeomPkg::ways-1:0] lineValid,
    input  logic tagWrite,
    input  cacheGeomPkg::wayT writeWay,
    input  cacheGeomPkg::wayT victimWay,
    output logic hit,
    output cacheGeomPkg::wayT hitWay,
    output cacheGeomPkg::tagT victimTag
);
    cacheGeomPkg::tagT storedTag [cacheGeomPkg::ways];
    logic [cacheGeomPkg::ways-1:0] wayHit;

    // one tag RAM per way, all read with the same set every cycle
    for (genvar w = 0; w < cacheGeomPkg::ways; w++) begin : gWay
        logic wayWrite;

        // refill stores the request tag into the chosen way
        assign wayWrite = tagWrite && (writeWay == cacheGeomPkg::wayT'(w));

        cacheArray #(
            .payloadT(cacheGeomPkg::tagT),
            .depth(cacheGeomPkg::sets)
        ) tagRam (
            .clock(clock),
            .address(set),
            .writeEnable(wayWrite),
            .writeMask('1),
            .writeData(tag),
            .readData(storedTag[w])
        );

        // invalid lines never match
        assign wayHit[w] = lineValid[w] && (storedTag[w] == tag);
    end

    assign hit = |wayHit;

    // highest matching way wins
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < cacheGeomPkg::ways; w++) begin
            if (wayHit[w]) begin
                hitWay = cacheGeomPkg::wayT'(w);
            end
        end
    end

    // tag of the line being evicted, for the writeback address
    assign victimTag = storedTag[victimWay];
endmodule

// File: source/lineStatus.sv
module lineStatus (
    input  logic clock,
    input  logic reset,
    input  cacheGeomPkg::lineIndexT lineIndex,
    input  logic setValid,
    input  logic dirtyWrite,
    input  logic dirtyValue,
    output logic valid,
    output logic dirty,
    output logic [cacheGeomPkg::ways-1:0] wayValid
);
    // one bit per way, grouped by set
    logic [cacheGeomPkg::ways-1:0] validBits [cacheGeomPkg::sets];
    logic [cacheGeomPkg::ways-1:0] dirtyBits [cacheGeomPkg::sets];
    cacheGeomPkg::setT set;
    cacheGeomPkg::wayT way;

    // line index is {set, way}
    assign set = cacheGeomPkg::setT'(lineIndex >> cacheGeomPkg::wayBits);
    assign way = cacheGeomPkg::wayT'(lineIndex);

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '{default: '0};
            dirtyBits <= '{default: '0};
        end else begin
            // refill done
            if (setValid) begin
                validBits[set][way] <= 1'b1;
            end
            // set on write hit, clear after writeback
            if (dirtyWrite) begin
                dirtyBits[set][way] <= dirtyValue;
            end
        end
    end

    // combinational reads
    assign valid = validBits[set][way];
    assign dirty = dirtyBits[set][way];
    // whole set, for the tag compare
    assign wayValid = validBits[set];

    // a finishing refill never coincides with a write hit marking dirty
    assert property (@(posedge clock) disable iff (reset)
        !(setValid && dirtyWrite && dirtyValue));
endmodule

// File: source/cacheArray.sv
module cacheArray #(
    parameter type payloadT = logic [7:0],
    parameter int depth = 16
) (
    input  logic clock,
    input  logic [$clog2(depth)-1:0] address,
    input  logic writeEnable,
    input  payloadT writeMask,
    input  payloadT writeData,
    output payloadT readData
);
    // storage, no reset on contents
    payloadT memory [depth];
    payloadT merged;

    // keep unmasked bits, take masked bits from writeData
    assign merged = payloadT'((memory[address] & ~writeMask) | (writeData & writeMask));

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memory[address] <= merged;
        end
    end

    // read-before-write, old contents one cycle later
    always_ff @(posedge clock) begin
        readData <= memory[address];
    end
endmodule

// File: source/cacheBusPkg.sv
`include "cache_cfg.svh"

package cacheBusPkg;
    // processor request, strobe is one cycle wide
    typedef struct packed {
        logic strobe;
        logic write;
        cacheGeomPkg::addrT addr;
        cacheGeomPkg::wordT writeData;
        cacheGeomPkg::byteMaskT mask;
    } cpuReqT;

    // completion strobe with read data in the same cycle
    typedef struct packed {
        logic dataOk;
        cacheGeomPkg::wordT readData;
    } cpuRspT;

    // cache to memory, valid side of each channel
    typedef struct packed {
        logic arValid;
        logic [`CACHE_ADDR_WIDTH-1:0] arAddr;
        logic awValid;
        logic [`CACHE_ADDR_WIDTH-1:0] awAddr;
        logic wValid;
        cacheGeomPkg::wordT wData;
        logic wLast;
        logic rReady;
    } memReqT;

    // memory to cache, ready side plus read data
    typedef struct packed {
        logic arReady;
        logic rValid;
        logic rLast;
        cacheGeomPkg::wordT rData;
        logic awReady;
        logic wReady;
    } memRspT;
endpackage

// File: source/cacheGeomPkg.sv
`include "cache_cfg.svh"

package cacheGeomPkg;
    // geometry pulled from the config macros
    localparam int addrWidth = `CACHE_ADDR_WIDTH;
    localparam int sets = `CACHE_SETS;
    localparam int ways = `CACHE_WAYS;
    localparam int lineBytes = `CACHE_LINE_BYTES;
    localparam int wordBytes = `CACHE_WORD_BYTES;

    // derived field widths
    localparam int offsetBits = $clog2(lineBytes);
    localparam int setBits = $clog2(sets);
    localparam int wayBits = $clog2(ways);
    localparam int tagBits = addrWidth - setBits - offsetBits;
    // set and way together pick one of the lines
    localparam int lineIndexBits = setBits + wayBits;

    typedef logic [tagBits-1:0] tagT;
    typedef logic [setBits-1:0] setT;
    typedef logic [offsetBits-1:0] offsetT;
    typedef logic [wayBits-1:0] wayT;
    typedef logic [lineIndexBits-1:0] lineIndexT;
    typedef logic [lineBytes*8-1:0] lineT;
    typedef logic [wordBytes*8-1:0] wordT;
    typedef logic [wordBytes-1:0] byteMaskT;

    // address split, tag on top
    typedef struct packed {
        tagT tag;
        setT set;
        offsetT offset;
    } addrT;
endpackage

// File: include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address seen by the processor and the memory bus
`define CACHE_ADDR_WIDTH 32

// number of sets
`define CACHE_SETS 16

// ways per set
`define CACHE_WAYS 4

// bytes per cache line
`define CACHE_LINE_BYTES 16

// processor data width and bus beat width, in bytes
`define CACHE_WORD_BYTES 8

// victim LFSR start value, must be nonzero
`define CACHE_LFSR_SEED 16'h0001

`endif
